//--- sim.f
hw/datapathPkg.sv
hw/busPkg.sv
hw/registerFile.sv
hw/alu.sv
hw/busEncoder.sv
hw/datapath.sv
dv/datapathTb.sv

//--- Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module datapathTb -Mdir obj_dir

run: compile
	./obj_dir/VdatapathTb 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/datapathTb.sv
module datapathTb
    import datapathPkg::*;
();
    timeunit 1ns;
    timeprecision 10ps;

    localparam int maxCycles = 20000;  // The tests need under 2000 cycles

    logic               Clock;
    logic               reset;
    logic [numRegs-1:0] regOut;
    logic [numRegs-1:0] regIn;
    logic   hiOut, hiIn, loOut, loIn, pcOut, pcIn, incPc, zHighOut, zLowOut, zIn;
    logic   mdrOut, mdrIn, read, marIn, irIn, yIn, inPortOut;
    aluOp_t aluOp;
    word_t  mDataIn, inPortData, busData, marValue, irValue;
    int     cycleCount = 0;
    int     errorCount = 0;
    int     startErrors = 0;   // Error count when the current test began
    int     testCount = 0;

    datapath i_dut (.*);

    initial Clock = 1'b0;
    always #5 Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == maxCycles) begin
            $display("Timeout: the tests were still running after %0d cycles", maxCycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic clearStrobes();
        regOut = '0;
        regIn  = '0;
        {hiOut, hiIn, loOut, loIn, pcOut, pcIn, incPc, zHighOut, zLowOut, zIn} = '0;
        {mdrOut, mdrIn, read, marIn, irIn, yIn, inPortOut} = '0;
        aluOp = opAdd;
    endtask

    // Strobes set at the falling edge take effect on the next rising edge
    task automatic endCycle();
        @(posedge Clock);
        @(negedge Clock);
        clearStrobes();
    endtask

    // Loads a memory word into the MDR and leaves the MDR driving the bus
    task automatic mdrToBus(input word_t value);
        mDataIn = value;
        {read, mdrIn} = '1;
        endCycle();
        mdrOut = 1'b1;
    endtask

    task automatic sampleBus(output word_t value);
        #2 value = busData;  // Bus has settled by mid low phase
        endCycle();
    endtask

    task automatic checkWord(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic checkDword(input string name, input dword_t actual, input dword_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic expectBus(input string name, input word_t expected);
        word_t value;
        sampleBus(value);
        checkWord(name, value, expected);
    endtask

    task automatic readZ(output dword_t z);
        word_t upper;
        word_t lower;
        zHighOut = 1'b1;
        sampleBus(upper);
        zLowOut = 1'b1;
        sampleBus(lower);
        z = {upper, lower};
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errorCount == startErrors) $display("%s: ok", name);
        else $display("%s: %0d checks failed", name, errorCount - startErrors);
        startErrors = errorCount;
    endtask

    // Reference ALU behavior with Z high zero for everything but the multiply
    function automatic dword_t expectedAlu(aluOp_t op, word_t a, word_t b);
        int    s;
        word_t r;
        s = b % 32;
        case (op)
            opAdd:   r = a + b;
            opSub:   r = a + ~b + 1;
            opAnd:   r = a & b;
            opOr:    r = a | b;
            opShr:   r = a >> s;
            opShra:  r = (a >> s) | (a[31] ? ~(32'hFFFF_FFFF >> s) : 32'h0);
            opShl:   r = a << s;
            opRor:   r = (s == 0) ? a : (a >> s) | (a << (32 - s));
            opRol:   r = (s == 0) ? a : (a << s) | (a >> (32 - s));
            opNeg:   r = 32'h0 - b;
            opNot:   r = b ^ 32'hFFFF_FFFF;
            default: r = '0;
        endcase
        return {32'h0, r};
    endfunction

    task automatic resetValues();
        for (int i = 0; i < numRegs; i++) begin
            regOut[i] = 1'b1;
            expectBus($sformatf("R%0d", i), '0);
        end
        hiOut = 1'b1;
        expectBus("HI", '0);
        loOut = 1'b1;
        expectBus("LO", '0);
        pcOut = 1'b1;
        expectBus("PC", '0);
        mdrOut = 1'b1;
        expectBus("MDR", '0);
        zLowOut = 1'b1;
        expectBus("Z low", '0);
        zHighOut = 1'b1;
        expectBus("Z high", '0);
        checkWord("marValue", marValue, '0);
        checkWord("irValue", irValue, '0);
        finishTest("reset values");
    endtask

    task automatic registerReadback();
        word_t expected [numRegs+2];  // R0 to R15 followed by HI and LO
        for (int i = 0; i < numRegs + 2; i++) begin
            expected[i] = $urandom;
            mdrToBus(expected[i]);
            if (i < numRegs) regIn[i] = 1'b1;
            else if (i == numRegs) hiIn = 1'b1;
            else loIn = 1'b1;
            endCycle();
        end
        for (int i = 0; i < numRegs; i++) begin
            regOut[i] = 1'b1;
            expectBus($sformatf("R%0d", i), expected[i]);
        end
        hiOut = 1'b1;
        expectBus("HI", expected[numRegs]);
        loOut = 1'b1;
        expectBus("LO", expected[numRegs+1]);
        inPortData = $urandom;
        inPortOut = 1'b1;
        expectBus("inPort", inPortData);
        finishTest("register readback");
    endtask

    task automatic addSequence();
        word_t pcStart;
        word_t instr;
        pcStart = $urandom;
        instr   = $urandom;
        mdrToBus(32'hFFFF_FFFB);  // -5
        regIn[2] = 1'b1;
        endCycle();
        mdrToBus(32'd6);
        regIn[3] = 1'b1;
        endCycle();
        mdrToBus(pcStart);
        pcIn = 1'b1;
        endCycle();
        {pcOut, marIn, incPc, zIn} = '1;  // T0
        aluOp = opMul;  // incPc must win over this
        endCycle();
        checkWord("marValue", marValue, pcStart);
        zLowOut = 1'b1;
        expectBus("Z low after T0", pcStart + 1);
        mDataIn = instr;
        {zLowOut, pcIn, read, mdrIn} = '1;  // T1
        endCycle();
        {mdrOut, irIn} = '1;  // T2
        endCycle();
        checkWord("irValue", irValue, instr);
        pcOut = 1'b1;
        expectBus("PC after T1", pcStart + 1);
        regOut[2] = 1'b1;  // T3
        yIn = 1'b1;
        endCycle();
        regOut[3] = 1'b1;  // T4
        aluOp = opAdd;
        zIn = 1'b1;
        endCycle();
        zLowOut = 1'b1;  // T5
        regIn[1] = 1'b1;
        endCycle();
        regOut[1] = 1'b1;
        expectBus("R1", 32'd1);
        finishTest("add sequence");
    endtask

    task automatic aluOperations();
        word_t  a;
        word_t  b;
        aluOp_t op;
        dword_t z;
        for (int n = 0; n < 200; n++) begin
            a = $urandom;
            b = $urandom;
            do op = aluOp_t'($urandom_range(0, 11)); while (op == opMul);
            mdrToBus(a);
            yIn = 1'b1;
            endCycle();
            mdrToBus(b);
            aluOp = op;
            zIn = 1'b1;
            endCycle();
            readZ(z);
            checkDword($sformatf("Z for %s", op.name()), z, expectedAlu(op, a, b));
        end
        finishTest("ALU operations");
    endtask

    task automatic signedMultiply();
        word_t  a;
        word_t  b;
        word_t  hiWord;
        word_t  loWord;
        dword_t product;
        for (int n = 0; n < 50; n++) begin
            a = $urandom;
            b = $urandom;
            product = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            mdrToBus(a);
            yIn = 1'b1;
            endCycle();
            mdrToBus(b);
            aluOp = opMul;
            zIn = 1'b1;
            endCycle();
            {zHighOut, hiIn} = '1;
            endCycle();
            {zLowOut, loIn} = '1;
            endCycle();
            hiOut = 1'b1;
            sampleBus(hiWord);
            loOut = 1'b1;
            sampleBus(loWord);
            checkDword("HI:LO product", {hiWord, loWord}, product);
        end
        finishTest("signed multiply");
    endtask

    task automatic mdrAndLoadStrobes();
        word_t busWord;
        word_t oldMar;
        word_t oldIr;
        busWord = $urandom;
        mDataIn = ~busWord;  // MDR starts out different from R4
        inPortData = busWord;
        {read, mdrIn, inPortOut} = '1;
        regIn[4] = 1'b1;
        endCycle();
        regOut[4] = 1'b1;  // MDR loads from the bus with read low
        mdrIn = 1'b1;
        endCycle();
        mdrOut = 1'b1;
        expectBus("MDR from bus", busWord);
        oldMar = marValue;
        oldIr  = irValue;
        inPortData = ~oldMar;
        inPortOut = 1'b1;
        endCycle();
        checkWord("marValue without marIn", marValue, oldMar);
        checkWord("irValue without irIn", irValue, oldIr);
        {inPortOut, marIn} = '1;
        endCycle();
        checkWord("marValue", marValue, ~oldMar);
        inPortData = ~oldIr;
        {inPortOut, irIn} = '1;
        endCycle();
        checkWord("irValue", irValue, ~oldIr);
        checkWord("marValue without marIn", marValue, ~oldMar);
        finishTest("MDR source and load strobes");
    endtask

    initial begin
        void'($urandom(32'h8472));
        reset      = 1'b1;
        mDataIn    = '0;
        inPortData = '0;
        clearStrobes();
        repeat (10) @(posedge Clock);
        @(negedge Clock);
        reset = 1'b0;
        resetValues();
        registerReadback();
        addSequence();
        aluOperations();
        signedMultiply();
        mdrAndLoadStrobes();
        $display("%0d tests run, %0d checks failed", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- hw/datapath.sv
module datapath
    import datapathPkg::*;
    import busPkg::*;
(
    input  logic               Clock,
    input  logic               reset,
    input  logic [numRegs-1:0] regOut,
    input  logic [numRegs-1:0] regIn,
    input  logic               hiOut,
    input  logic               hiIn,
    input  logic               loOut,
    input  logic               loIn,
    input  logic               pcOut,
    input  logic               pcIn,
    input  logic               incPc,
    input  logic               zHighOut,
    input  logic               zLowOut,
    input  logic               zIn,
    input  logic               mdrOut,
    input  logic               mdrIn,
    input  logic               read,      // MDR source select, memory when high
    input  logic               marIn,
    input  logic               irIn,
    input  logic               yIn,
    input  logic               inPortOut,
    input  aluOp_t             aluOp,
    input  word_t              mDataIn,
    input  word_t              inPortData,
    output word_t              busData,
    output word_t              marValue,
    output word_t              irValue
);

    word_t   pc;
    word_t   y;
    dword_t  z;
    word_t   mdr;
    word_t   hi;
    word_t   lo;
    word_t   regData;
    dword_t  aluResult;
    busSrc_t busSrc;

    registerFile u_registerFile (
        .Clock   (Clock),
        .reset   (reset),
        .regIn   (regIn),
        .regOut  (regOut),
        .busIn   (busData),
        .regData (regData)
    );

    alu u_alu (
        .opA    (y),
        .opB    (busData),
        .aluOp  (aluOp),
        .incPc  (incPc),
        .result (aluResult)
    );

    busEncoder u_busEncoder (
        .Clock      (Clock),
        .reset      (reset),
        .regOut     (regOut),
        .regData    (regData),
        .hiOut      (hiOut),
        .loOut      (loOut),
        .zHighOut   (zHighOut),
        .zLowOut    (zLowOut),
        .pcOut      (pcOut),
        .mdrOut     (mdrOut),
        .inPortOut  (inPortOut),
        .hiValue    (hi),
        .loValue    (lo),
        .zValue     (z),
        .pcValue    (pc),
        .mdrValue   (mdr),
        .inPortData (inPortData),
        .busData    (busData),
        .busSrc     (busSrc)
    );

    // Special registers, each loads on its own in strobe
    always_ff @(posedge Clock) begin
        if (reset) begin
            pc       <= '0;
            irValue  <= '0;
            y        <= '0;
            z        <= '0;
            marValue <= '0;
            mdr      <= '0;
            hi       <= '0;
            lo       <= '0;
        end else begin
            if (pcIn)  pc       <= busData;
            if (irIn)  irValue  <= busData;
            if (yIn)   y        <= busData;
            if (zIn)   z        <= aluResult;  // Y op bus
            if (marIn) marValue <= busData;
            if (hiIn)  hi       <= busData;
            if (loIn)  lo       <= busData;
            if (mdrIn) begin
                mdr <= read ? mDataIn : busData;
            end
        end
    end

    readWithMdrIn: assert property (
        @(posedge Clock) disable iff (reset)
        read |-> mdrIn
    ) else $error("datapath: read without mdrIn");

    // PC increment only makes sense with PC on the bus
    incPcFromPc: assert property (
        @(posedge Clock) disable iff (reset)
        (zIn && incPc) |-> (busSrc == srcPc)
    ) else $error("datapath: incPc with a source other than PC");

endmodule

//--- hw/busEncoder.sv
module busEncoder
    import datapathPkg::*;
    import busPkg::*;
(
    input  logic               Clock,
    input  logic               reset,
    input  logic [numRegs-1:0] regOut,
    input  word_t              regData,
    input  logic               hiOut,
    input  logic               loOut,
    input  logic               zHighOut,
    input  logic               zLowOut,
    input  logic               pcOut,
    input  logic               mdrOut,
    input  logic               inPortOut,
    input  word_t              hiValue,
    input  word_t              loValue,
    input  dword_t             zValue,
    input  word_t              pcValue,
    input  word_t              mdrValue,
    input  word_t              inPortData,
    output word_t              busData,
    output busSrc_t            busSrc
);

    logic [numRegs+6:0] strobes;  // Every out strobe, for the legality check

    assign strobes = {regOut, hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut};

    always_comb begin
        if (|regOut)        busSrc = srcReg;
        else if (hiOut)     busSrc = srcHi;
        else if (loOut)     busSrc = srcLo;
        else if (zHighOut)  busSrc = srcZHigh;
        else if (zLowOut)   busSrc = srcZLow;
        else if (pcOut)     busSrc = srcPc;
        else if (mdrOut)    busSrc = srcMdr;
        else if (inPortOut) busSrc = srcInPort;
        else                busSrc = srcNone;
    end

    always_comb begin
        case (busSrc)
            srcReg:    busData = regData;
            srcHi:     busData = hiValue;
            srcLo:     busData = loValue;
            srcZHigh:  busData = zValue[2*wordWidth-1:wordWidth];
            srcZLow:   busData = zValue[wordWidth-1:0];
            srcPc:     busData = pcValue;
            srcMdr:    busData = mdrValue;
            srcInPort: busData = inPortData;
            default:   busData = '0;  // Idle bus
        endcase
    end

    singleBusDriver: assert property (
        @(posedge Clock) disable iff (reset)
        $onehot0(strobes)
    ) else $error("busEncoder: more than one source driving the bus");

endmodule

//--- hw/alu.sv
module alu
    import datapathPkg::*;
(
    input  word_t  opA,     // Y register
    input  word_t  opB,     // Bus
    input  aluOp_t aluOp,
    input  logic   incPc,
    output dword_t result
);

    logic [4:0] shamt;
    word_t      low;                           // Result of the 32-bit operations
    dword_t     rorWide;
    dword_t     rolWide;
    logic signed [2*wordWidth-1:0] product;

    assign shamt = opB[4:0];  // Shift amount is taken modulo 32

    // Rotates shift a doubled copy of opA and keep one half
    assign rorWide = {opA, opA} >> shamt;
    assign rolWide = {opA, opA} << shamt;

    // Both operands sign-extend to 64 bits before the multiply
    assign product = $signed(opA) * $signed(opB);

    always_comb begin
        case (aluOp)
            opAdd:   low = opA + opB;
            opSub:   low = opA - opB;
            opAnd:   low = opA & opB;
            opOr:    low = opA | opB;
            opShr:   low = opA >> shamt;
            opShra:  low = word_t'($signed(opA) >>> shamt);
            opShl:   low = opA << shamt;
            opRor:   low = rorWide[wordWidth-1:0];
            opRol:   low = rolWide[2*wordWidth-1:wordWidth];
            opNeg:   low = -opB;
            opNot:   low = ~opB;
            default: low = '0;  // opMul and unused codes
        endcase
    end

    always_comb begin
        if (incPc) begin
            // PC increment during fetch wins over whatever aluOp holds
            result = {{wordWidth{1'b0}}, word_t'(opB + 1'b1)};
        end else if (aluOp == opMul) begin
            result = dword_t'(product);
        end else begin
            result = {{wordWidth{1'b0}}, low};  // Z high cleared
        end
    end

endmodule

//--- hw/registerFile.sv
module registerFile
    import datapathPkg::*;
(
    input  logic               Clock,
    input  logic               reset,
    input  logic [numRegs-1:0] regIn,   // One load strobe per register
    input  logic [numRegs-1:0] regOut,  // One-hot read select
    input  word_t              busIn,
    output word_t              regData
);

    word_t regs [numRegs];

    // Several registers may load the same bus value in one cycle
    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                if (regIn[i]) begin
                    regs[i] <= busIn;
                end
            end
        end
    end

    // AND-OR read mux, valid only while regOut is one-hot or zero
    always_comb begin
        regData = '0;
        for (int i = 0; i < numRegs; i++) begin
            if (regOut[i]) begin
                regData = regData | regs[i];
            end
        end
    end

    regOutOneHot: assert property (
        @(posedge Clock) disable iff (reset)
        $onehot0(regOut)
    ) else $error("registerFile: more than one register selected for read");

endmodule

//--- hw/busPkg.sv
package busPkg;

    // Which source drives the shared bus in the current cycle
    // srcReg covers all sixteen general registers; the one-hot regOut
    // vector says which of them
    typedef enum logic [4:0] {
        srcNone   = 5'd0,   // Bus reads zero
        srcReg    = 5'd1,
        srcHi     = 5'd2,
        srcLo     = 5'd3,
        srcZHigh  = 5'd4,
        srcZLow   = 5'd5,
        srcPc     = 5'd6,
        srcMdr    = 5'd7,
        srcInPort = 5'd8
    } busSrc_t;

endpackage

//--- hw/datapathPkg.sv
package datapathPkg;

    localparam int wordWidth = 32;  // Bus and register width
    localparam int numRegs   = 16;  // General registers R0 to R15

    typedef logic [wordWidth-1:0]   word_t;
    typedef logic [2*wordWidth-1:0] dword_t;  // Full Z, product width

    // ALU operations, encoded as the control unit issues them
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opShr  = 4'd4,   // Logical right
        opShra = 4'd5,   // Arithmetic right
        opShl  = 4'd6,
        opRor  = 4'd7,
        opRol  = 4'd8,
        opMul  = 4'd9,   // Signed, 64-bit product
        opNeg  = 4'd10,
        opNot  = 4'd11
    } aluOp_t;

endpackage
